// File: hdl/rename_pkg.sv
package rename_pkg;

	// machine sizes
	localparam int ARCH_NUM = 32;
	localparam int PHYS_NUM = 64;
	localparam int FL_DEPTH = PHYS_NUM - ARCH_NUM; // tags not held by the arch map
	localparam int DP_WIDTH = 2; // dispatch and retire slots

	// the restore walk copies four map rows per cycle
	localparam int RESTORE_ROWS = 4;
	localparam int RESTORE_STEPS = ARCH_NUM / RESTORE_ROWS;

	typedef logic [4:0] arch_reg_t;
	typedef logic [5:0] phys_tag_t;

	// the wrap bit above the index tells full from empty
	typedef logic [5:0] fl_ptr_t;

	typedef logic [1:0] avail_t; // 0 to 2 tags offered
	typedef logic [2:0] step_t;

	localparam phys_tag_t ZERO_TAG = '0; // x0 always maps here

	typedef enum logic {
		REC_IDLE,
		REC_RESTORE
	} rec_state_t;

endpackage

// File: hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
	input logic clk_i,
	input logic rst_i,
	input logic rollback_i,
	input logic block_i,
	input logic [rename_pkg::DP_WIDTH-1:0] dp_valid_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rd_i,
	input logic [rename_pkg::DP_WIDTH-1:0] free_valid_i,
	input rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] free_tag_i,
	output logic [rename_pkg::DP_WIDTH-1:0] alloc_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] alloc_tag_o,
	output rename_pkg::avail_t avail_o
);
	import rename_pkg::*;

	phys_tag_t fl_q [FL_DEPTH];

	fl_ptr_t rd_ptr_q; // next tag handed to dispatch
	fl_ptr_t wr_ptr_q; // next slot for a freed tag
	fl_ptr_t rb_ptr_q; // read position matching the retired state

	fl_ptr_t rd_ptr_d;
	fl_ptr_t wr_ptr_d;
	fl_ptr_t rb_ptr_d;

	fl_ptr_t rd_plus_one;
	fl_ptr_t wr_slot1; // where slot 1's freed tag lands
	fl_ptr_t fill; // tags currently in the list
	fl_ptr_t n_alloc;
	fl_ptr_t n_free;

	// a slot needs a tag only when valid and not writing x0
	always_comb begin
		for (int i = 0; i < DP_WIDTH; i++) begin
			alloc_o[i] = dp_valid_i[i] && (dp_rd_i[i] != '0) && !block_i;
		end
	end

	assign rd_plus_one = rd_ptr_q + fl_ptr_t'(1);

	assign alloc_tag_o[0] = alloc_o[0] ? fl_q[rd_ptr_q[$clog2(FL_DEPTH)-1:0]] : ZERO_TAG;

	// slot 1 only skips ahead when slot 0 actually took the head tag
	always_comb begin
		if (!alloc_o[1]) begin
			alloc_tag_o[1] = ZERO_TAG;
		end else if (alloc_o[0]) begin
			alloc_tag_o[1] = fl_q[rd_plus_one[$clog2(FL_DEPTH)-1:0]];
		end else begin
			alloc_tag_o[1] = fl_q[rd_ptr_q[$clog2(FL_DEPTH)-1:0]];
		end
	end

	assign n_alloc = fl_ptr_t'(alloc_o[0]) + fl_ptr_t'(alloc_o[1]);
	assign n_free = fl_ptr_t'(free_valid_i[0]) + fl_ptr_t'(free_valid_i[1]);

	assign fill = wr_ptr_q - rd_ptr_q;

	always_comb begin
		if (block_i) begin
			avail_o = '0; // no dispatch while the map is rebuilt
		end else if (fill >= fl_ptr_t'(2)) begin
			avail_o = avail_t'(2);
		end else begin
			avail_o = avail_t'(fill);
		end
	end

	assign wr_slot1 = wr_ptr_q + fl_ptr_t'(free_valid_i[0]);

	// every retired non-x0 write used exactly one allocation,
	// so the rollback point moves with the write pointer
	assign wr_ptr_d = wr_ptr_q + n_free;
	assign rb_ptr_d = rb_ptr_q + n_free;
	assign rd_ptr_d = rollback_i ? rb_ptr_d : rd_ptr_q + n_alloc;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= fl_ptr_t'(FL_DEPTH); // list starts full
			rb_ptr_q <= '0;
			for (int i = 0; i < FL_DEPTH; i++) begin
				fl_q[i] <= phys_tag_t'(ARCH_NUM + i); // tags 32..63
			end
		end else begin
			rd_ptr_q <= rd_ptr_d;
			wr_ptr_q <= wr_ptr_d;
			rb_ptr_q <= rb_ptr_d;
			if (free_valid_i[0]) begin
				fl_q[wr_ptr_q[$clog2(FL_DEPTH)-1:0]] <= free_tag_i[0];
			end
			if (free_valid_i[1]) begin
				fl_q[wr_slot1[$clog2(FL_DEPTH)-1:0]] <= free_tag_i[1];
			end
		end
	end

endmodule

// File: hdl/spec_map.sv
`timescale 1ns/1ps

module spec_map (
	input logic clk_i,
	input logic rst_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rd_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rs1_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rs2_i,
	input logic [rename_pkg::DP_WIDTH-1:0] alloc_i,
	input rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] alloc_tag_i,
	input logic restore_en_i,
	input rename_pkg::step_t step_i,
	input rename_pkg::phys_tag_t [rename_pkg::RESTORE_ROWS-1:0] restore_tags_i,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] prs1_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] prs2_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] told_o
);
	import rename_pkg::*;

	phys_tag_t map_q [ARCH_NUM];

	logic hit_rs1; // slot 1 reads what slot 0 writes
	logic hit_rs2;
	logic hit_rd; // both slots write the same register

	function automatic phys_tag_t lookup(input arch_reg_t r);
		return (r == '0) ? ZERO_TAG : map_q[r];
	endfunction

	// alloc_i[0] already excludes x0, so a match means a real producer
	assign hit_rs1 = alloc_i[0] && (dp_rs1_i[1] == dp_rd_i[0]);
	assign hit_rs2 = alloc_i[0] && (dp_rs2_i[1] == dp_rd_i[0]);
	assign hit_rd = alloc_i[0] && (dp_rd_i[1] == dp_rd_i[0]);

	always_comb begin
		// slot 0 sees only the table
		prs1_o[0] = lookup(dp_rs1_i[0]);
		prs2_o[0] = lookup(dp_rs2_i[0]);
		told_o[0] = lookup(dp_rd_i[0]);

		// slot 1 is younger and sees slot 0's new tag
		prs1_o[1] = hit_rs1 ? alloc_tag_i[0] : lookup(dp_rs1_i[1]);
		prs2_o[1] = hit_rs2 ? alloc_tag_i[0] : lookup(dp_rs2_i[1]);
		told_o[1] = hit_rd ? alloc_tag_i[0] : lookup(dp_rd_i[1]);
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < ARCH_NUM; i++) begin
				map_q[i] <= phys_tag_t'(i); // identity
			end
		end else if (restore_en_i) begin
			// copy one group of rows from the arch map
			for (int k = 0; k < RESTORE_ROWS; k++) begin
				map_q[int'(step_i) * RESTORE_ROWS + k] <= restore_tags_i[k];
			end
		end else begin
			// later slot overwrites, so slot 1 wins on a shared rd
			for (int i = 0; i < DP_WIDTH; i++) begin
				if (alloc_i[i]) begin
					map_q[dp_rd_i[i]] <= alloc_tag_i[i];
				end
			end
		end
	end

endmodule

// File: hdl/arch_map.sv
`timescale 1ns/1ps

module arch_map (
	input logic clk_i,
	input logic rst_i,
	input logic [rename_pkg::DP_WIDTH-1:0] rt_valid_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] rt_rd_i,
	input rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] rt_prd_i,
	input rename_pkg::step_t step_i,
	output logic [rename_pkg::DP_WIDTH-1:0] free_valid_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] free_tag_o,
	output rename_pkg::phys_tag_t [rename_pkg::RESTORE_ROWS-1:0] restore_tags_o
);
	import rename_pkg::*;

	phys_tag_t amap_q [ARCH_NUM];

	always_comb begin
		for (int i = 0; i < DP_WIDTH; i++) begin
			free_valid_o[i] = rt_valid_i[i] && (rt_rd_i[i] != '0);
		end
		free_tag_o[0] = amap_q[rt_rd_i[0]];
		// slot 0's mapping is already dead if slot 1 overwrites the same reg
		if (free_valid_o[0] && (rt_rd_i[1] == rt_rd_i[0])) begin
			free_tag_o[1] = rt_prd_i[0];
		end else begin
			free_tag_o[1] = amap_q[rt_rd_i[1]];
		end
	end

	always_comb begin
		for (int k = 0; k < RESTORE_ROWS; k++) begin
			restore_tags_o[k] = amap_q[int'(step_i) * RESTORE_ROWS + k];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < ARCH_NUM; i++) begin
				amap_q[i] <= phys_tag_t'(i);
			end
		end else begin
			for (int i = 0; i < DP_WIDTH; i++) begin
				if (free_valid_o[i]) begin
					amap_q[rt_rd_i[i]] <= rt_prd_i[i]; // commit in slot order
				end
			end
		end
	end

endmodule

// File: hdl/restore_counter.sv
`timescale 1ns/1ps

module restore_counter (
	input logic clk_i,
	input logic rst_i,
	input logic en_i,
	output rename_pkg::step_t step_o,
	output logic last_o
);
	import rename_pkg::*;

	step_t step_q;

	always_ff @(posedge clk_i) begin
		if (rst_i || !en_i) begin
			step_q <= '0; // parked at the first row group
		end else begin
			step_q <= step_q + step_t'(1); // wraps to 0 after the last step
		end
	end

	assign step_o = step_q;
	assign last_o = (step_q == step_t'(RESTORE_STEPS - 1));

endmodule

// File: hdl/recovery_fsm.sv
`timescale 1ns/1ps

module recovery_fsm (
	input logic clk_i,
	input logic rst_i,
	input logic rollback_i,
	input logic last_i,
	output logic busy_o,
	output logic restore_en_o
);
	import rename_pkg::*;

	rec_state_t state_q;
	rec_state_t state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			REC_IDLE: begin
				if (rollback_i) begin
					state_d = REC_RESTORE; // restore starts next cycle
				end
			end
			REC_RESTORE: begin
				if (last_i) begin
					state_d = REC_IDLE; // final row group copied this cycle
				end
			end
			default: begin
				state_d = REC_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= REC_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// busy blocks dispatch, restore_en drives the copy walk
	assign busy_o = (state_q == REC_RESTORE);
	assign restore_en_o = (state_q == REC_RESTORE);

endmodule

// File: hdl/rename_top.sv
`timescale 1ns/1ps

module rename_top (
	input logic clk_i,
	input logic rst_i,

	// dispatch side
	input logic [rename_pkg::DP_WIDTH-1:0] dp_valid_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rd_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rs1_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] dp_rs2_i,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] dp_prs1_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] dp_prs2_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] dp_prd_o,
	output rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] dp_told_o,
	output rename_pkg::avail_t dp_avail_o,

	// retire side
	input logic [rename_pkg::DP_WIDTH-1:0] rt_valid_i,
	input rename_pkg::arch_reg_t [rename_pkg::DP_WIDTH-1:0] rt_rd_i,
	input rename_pkg::phys_tag_t [rename_pkg::DP_WIDTH-1:0] rt_prd_i,

	input logic rollback_i,
	output logic busy_o
);
	import rename_pkg::*;

	logic [DP_WIDTH-1:0] alloc;
	logic [DP_WIDTH-1:0] free_valid;
	phys_tag_t [DP_WIDTH-1:0] free_tag;
	phys_tag_t [RESTORE_ROWS-1:0] restore_tags;
	step_t step;
	logic last;
	logic restore_en;

	free_list u_free_list (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.rollback_i(rollback_i),
		.block_i(busy_o),
		.dp_valid_i(dp_valid_i),
		.dp_rd_i(dp_rd_i),
		.free_valid_i(free_valid),
		.free_tag_i(free_tag),
		.alloc_o(alloc),
		.alloc_tag_o(dp_prd_o), // new tags go straight out and into the map
		.avail_o(dp_avail_o)
	);

	spec_map u_spec_map (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dp_rd_i(dp_rd_i),
		.dp_rs1_i(dp_rs1_i),
		.dp_rs2_i(dp_rs2_i),
		.alloc_i(alloc),
		.alloc_tag_i(dp_prd_o),
		.restore_en_i(restore_en),
		.step_i(step),
		.restore_tags_i(restore_tags),
		.prs1_o(dp_prs1_o),
		.prs2_o(dp_prs2_o),
		.told_o(dp_told_o)
	);

	arch_map u_arch_map (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.rt_valid_i(rt_valid_i),
		.rt_rd_i(rt_rd_i),
		.rt_prd_i(rt_prd_i),
		.step_i(step),
		.free_valid_o(free_valid),
		.free_tag_o(free_tag),
		.restore_tags_o(restore_tags)
	);

	restore_counter u_restore_counter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.en_i(restore_en),
		.step_o(step),
		.last_o(last)
	);

	recovery_fsm u_recovery_fsm (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.rollback_i(rollback_i),
		.last_i(last),
		.busy_o(busy_o),
		.restore_en_o(restore_en)
	);

endmodule

// File: sim/rename_sva.sv
`timescale 1ns/1ps

module rename_sva (
	input logic clk_i,
	input logic rst_i,
	input logic [1:0] dp_valid_i,
	input rename_pkg::arch_reg_t [1:0] dp_rd_i,
	input rename_pkg::phys_tag_t [1:0] dp_prd_o,
	input rename_pkg::avail_t dp_avail_o,
	input logic rollback_i,
	input logic busy_o
);
	import rename_pkg::*;

	int sva_errors = 0;
	logic [1:0] wants; // slots that need a new tag
	logic [1:0] n_wants;
	logic [3:0] busy_len; // busy cycles seen so far

	assign wants[0] = dp_valid_i[0] && (dp_rd_i[0] != '0);
	assign wants[1] = dp_valid_i[1] && (dp_rd_i[1] != '0);
	assign n_wants = {1'b0, wants[0]} + {1'b0, wants[1]};

	always_ff @(posedge clk_i) begin
		if (rst_i || !busy_o) begin
			busy_len <= '0;
		end else begin
			busy_len <= busy_len + 4'd1;
		end
	end

	assert property (@(posedge clk_i) disable iff (rst_i) n_wants <= dp_avail_o)
		else begin
			$error("dispatch took more tags than dp_avail_o offered");
			sva_errors++;
		end

	assert property (@(posedge clk_i) disable iff (rst_i) rollback_i && !busy_o |=> busy_o)
		else begin
			$error("busy_o did not rise after rollback");
			sva_errors++;
		end

	// one busy cycle per restore step
	assert property (@(posedge clk_i) disable iff (rst_i)
			$fell(busy_o) |-> busy_len == 4'(RESTORE_STEPS))
		else begin
			$error("busy_o length differs from the restore walk");
			sva_errors++;
		end

	assert property (@(posedge clk_i) disable iff (rst_i)
			!busy_o |-> (!wants[0] || dp_prd_o[0] != '0) &&
				(!wants[1] || dp_prd_o[1] != '0))
		else begin
			$error("an allocated tag was 0");
			sva_errors++;
		end

endmodule

bind rename_top rename_sva u_sva (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.dp_valid_i(dp_valid_i),
	.dp_rd_i(dp_rd_i),
	.dp_prd_o(dp_prd_o),
	.dp_avail_o(dp_avail_o),
	.rollback_i(rollback_i),
	.busy_o(busy_o)
);

// File: sim/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
	import rename_pkg::*;

	localparam int WAIT_LIMIT = 64;

	logic clk_i = 1'b0;
	logic rst_i;
	logic [1:0] dp_valid_i;
	arch_reg_t [1:0] dp_rd_i;
	arch_reg_t [1:0] dp_rs1_i;
	arch_reg_t [1:0] dp_rs2_i;
	phys_tag_t [1:0] dp_prs1_o;
	phys_tag_t [1:0] dp_prs2_o;
	phys_tag_t [1:0] dp_prd_o;
	phys_tag_t [1:0] dp_told_o;
	avail_t dp_avail_o;
	logic [1:0] rt_valid_i;
	arch_reg_t [1:0] rt_rd_i;
	phys_tag_t [1:0] rt_prd_i;
	logic rollback_i;
	logic busy_o;

	phys_tag_t smap [ARCH_NUM]; // model of the speculative map
	phys_tag_t amap [ARCH_NUM];
	phys_tag_t free_q [$];
	arch_reg_t pend_rd_q [$]; // dispatched, not yet retired
	phys_tag_t pend_prd_q [$];
	int rec_left; // busy cycles still expected
	int errors;
	int checks;
	int test_errors;
	int n;
	logic [31:0] rng;
	logic [1:0] t_dv;
	logic [1:0] t_rtv;
	arch_reg_t [1:0] t_rd;
	arch_reg_t [1:0] t_rs1;
	arch_reg_t [1:0] t_rs2;
	phys_tag_t exp_head;

	always #2 clk_i = ~clk_i;

	rename_top u_dut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic phys_tag_t model_read(input arch_reg_t r);
		return (r == '0) ? '0 : smap[r];
	endfunction

	task automatic compare_tag(input string name, input phys_tag_t exp, input phys_tag_t act);
		checks++;
		assert (exp == act) else begin
			$display("Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// drives on the rising edge and checks and steps the model at the falling edge
	task automatic run_cycle(input logic [1:0] dv, input arch_reg_t [1:0] rd,
			input arch_reg_t [1:0] rs1, input arch_reg_t [1:0] rs2,
			input logic [1:0] rtv, input logic rb);
		logic [1:0] v;
		logic [1:0] rv;
		arch_reg_t [1:0] rrd;
		phys_tag_t [1:0] rprd;
		phys_tag_t tmp_q [$];
		phys_tag_t e_prd;
		int avail;
		int used;
		avail = (rec_left > 0) ? 0 : ((free_q.size() >= 2) ? 2 : free_q.size());
		v = rb ? 2'b00 : dv;
		used = 0;
		for (int i = 0; i < 2; i++) begin
			if (v[i] && rd[i] != '0) begin
				if (used < avail) begin
					used++;
				end else begin
					v[i] = 1'b0; // caller stays within dp_avail_o
				end
			end
		end
		rv = '0;
		rrd = '0;
		rprd = '0;
		for (int i = 0; i < 2; i++) begin
			if (rtv[i] && !rb && rec_left == 0 && pend_rd_q.size() > 0) begin
				rv[i] = 1'b1;
				rrd[i] = pend_rd_q.pop_front();
				rprd[i] = pend_prd_q.pop_front();
			end
		end
		@(posedge clk_i);
		dp_valid_i <= v;
		dp_rd_i <= rd;
		dp_rs1_i <= rs1;
		dp_rs2_i <= rs2;
		rt_valid_i <= rv;
		rt_rd_i <= rrd;
		rt_prd_i <= rprd;
		rollback_i <= rb;
		@(negedge clk_i);
		compare_tag("dp_avail_o", phys_tag_t'(avail), phys_tag_t'(dp_avail_o));
		compare_tag("busy_o", phys_tag_t'(rec_left > 0), phys_tag_t'(busy_o));
		for (int i = 0; i < 2; i++) begin
			if (v[i]) begin
				compare_tag($sformatf("dp_prs1_o[%0d]", i), model_read(rs1[i]), dp_prs1_o[i]);
				compare_tag($sformatf("dp_prs2_o[%0d]", i), model_read(rs2[i]), dp_prs2_o[i]);
				compare_tag($sformatf("dp_told_o[%0d]", i), model_read(rd[i]), dp_told_o[i]);
				e_prd = '0;
				if (rd[i] != '0) begin
					e_prd = free_q.pop_front();
					smap[rd[i]] = e_prd; // slot 1 sees this, like the bypass
				end
				compare_tag($sformatf("dp_prd_o[%0d]", i), e_prd, dp_prd_o[i]);
				pend_rd_q.push_back(rd[i]);
				pend_prd_q.push_back(e_prd);
			end
		end
		for (int i = 0; i < 2; i++) begin
			if (rv[i] && rrd[i] != '0) begin
				free_q.push_back(amap[rrd[i]]); // old architectural tag
				amap[rrd[i]] = rprd[i];
			end
		end
		if (rec_left > 0) begin
			rec_left--;
		end
		if (rb) begin
			// unretired tags go back ahead of the free ones, oldest first
			for (int i = 0; i < pend_rd_q.size(); i++) begin
				if (pend_rd_q[i] != '0) begin
					tmp_q.push_back(pend_prd_q[i]);
				end
			end
			for (int i = tmp_q.size() - 1; i >= 0; i--) begin
				free_q.push_front(tmp_q[i]);
			end
			pend_rd_q.delete();
			pend_prd_q.delete();
			for (int r = 0; r < ARCH_NUM; r++) begin
				smap[r] = amap[r];
			end
			rec_left = RESTORE_STEPS;
		end
	endtask

	task automatic idle_cycle();
		run_cycle('0, '0, '0, '0, '0, 1'b0);
	endtask

	task automatic wait_restore(output int high_cycles);
		int k;
		k = 0;
		high_cycles = 0;
		do begin
			idle_cycle();
			k++;
			if (busy_o) begin
				high_cycles++;
			end
		end while ((busy_o || high_cycles == 0) && k < WAIT_LIMIT);
		if (k >= WAIT_LIMIT) begin
			$display("timeout: busy_o did not fall after rollback");
			$display("*** FAILED ***");
			$finish;
		end
	endtask

	initial begin
		rst_i = 1'b1;
		dp_valid_i = '0;
		dp_rd_i = '0;
		dp_rs1_i = '0;
		dp_rs2_i = '0;
		rt_valid_i = '0;
		rt_rd_i = '0;
		rt_prd_i = '0;
		rollback_i = 1'b0;
		rng = 32'h864396c9;
		errors = 0;
		checks = 0;
		test_errors = 0;
		rec_left = 0;
		for (int r = 0; r < ARCH_NUM; r++) begin
			smap[r] = phys_tag_t'(r); // identity after reset
			amap[r] = phys_tag_t'(r);
			free_q.push_back(phys_tag_t'(ARCH_NUM + r));
		end
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;

		t_rd[0] = 5'd1;
		t_rd[1] = 5'd2;
		t_rs1[0] = 5'd3;
		t_rs1[1] = 5'd5;
		t_rs2[0] = 5'd4;
		t_rs2[1] = 5'd6;
		run_cycle(2'b11, t_rd, t_rs1, t_rs2, 2'b00, 1'b0);
		compare_tag("dp_prd_o[0]", 6'd32, dp_prd_o[0]);
		compare_tag("dp_prd_o[1]", 6'd33, dp_prd_o[1]);
		compare_tag("dp_prs1_o[0]", 6'd3, dp_prs1_o[0]);
		report_test("1 reset state");

		t_rd[0] = 5'd0;
		t_rd[1] = 5'd7;
		t_rs1[0] = 5'd0;
		t_rs1[1] = 5'd0;
		t_rs2[0] = 5'd9;
		t_rs2[1] = 5'd1;
		run_cycle(2'b11, t_rd, t_rs1, t_rs2, 2'b00, 1'b0);
		compare_tag("dp_prd_o[0]", 6'd0, dp_prd_o[0]);
		compare_tag("dp_prd_o[1]", 6'd34, dp_prd_o[1]); // x0 did not use 34
		compare_tag("dp_prs1_o[0]", 6'd0, dp_prs1_o[0]);
		compare_tag("dp_prs2_o[1]", 6'd32, dp_prs2_o[1]);
		report_test("4 x0 handling");

		run_cycle('0, '0, '0, '0, 2'b11, 1'b0); // frees 1 and 2
		run_cycle('0, '0, '0, '0, 2'b11, 1'b0); // frees 7
		for (int c = 0; c < 16; c++) begin
			rng = xorshift(rng);
			t_rd[0] = arch_reg_t'(8 + (c % 8));
			t_rd[1] = arch_reg_t'(16 + (c % 8));
			t_rs1 = rng[9:0];
			t_rs2 = rng[19:10];
			run_cycle(2'b11, t_rd, t_rs1, t_rs2, 2'b00, 1'b0);
		end
		compare_tag("dp_prd_o[0]", 6'd2, dp_prd_o[0]); // after 35..63 and tag 1
		compare_tag("dp_prd_o[1]", 6'd7, dp_prd_o[1]);
		report_test("3 free list order");

		for (int c = 0; c < 300; c++) begin
			rng = xorshift(rng);
			t_dv = rng[1:0];
			t_rd[0] = arch_reg_t'(rng[4:2]); // few registers give many collisions
			t_rd[1] = arch_reg_t'(rng[7:5]);
			t_rs1[0] = arch_reg_t'(rng[10:8]);
			t_rs1[1] = arch_reg_t'(rng[13:11]);
			t_rs2[0] = arch_reg_t'(rng[16:14]);
			t_rs2[1] = arch_reg_t'(rng[19:17]);
			t_rtv = rng[21:20];
			run_cycle(t_dv, t_rd, t_rs1, t_rs2, t_rtv, 1'b0);
		end
		report_test("2 random dispatch and retire");

		exp_head = free_q[0];
		for (int i = pend_rd_q.size() - 1; i >= 0; i--) begin
			if (pend_rd_q[i] != '0) begin
				exp_head = pend_prd_q[i];
			end
		end
		run_cycle('0, '0, '0, '0, '0, 1'b1);
		wait_restore(n);
		compare_tag("busy_o cycles", 6'd8, phys_tag_t'(n));
		for (int c = 0; c < 8; c++) begin
			t_rs1[0] = arch_reg_t'(4 * c);
			t_rs2[0] = arch_reg_t'(4 * c + 1);
			t_rs1[1] = arch_reg_t'(4 * c + 2);
			t_rs2[1] = arch_reg_t'(4 * c + 3);
			run_cycle(2'b11, '0, t_rs1, t_rs2, 2'b00, 1'b0);
		end
		t_rd[0] = 5'd5;
		run_cycle(2'b01, t_rd, '0, '0, 2'b00, 1'b0);
		compare_tag("dp_prd_o[0]", exp_head, dp_prd_o[0]);
		report_test("6 rollback");

		// retire all in flight so the next retire is a real destination
		n = 0;
		while (pend_rd_q.size() > 0 && n < WAIT_LIMIT) begin
			run_cycle('0, '0, '0, '0, 2'b11, 1'b0);
			n++;
		end
		n = 0;
		while (free_q.size() > 0 && n < WAIT_LIMIT) begin
			t_rd[0] = arch_reg_t'(1 + (n % 31));
			t_rd[1] = arch_reg_t'(31 - (n % 31));
			run_cycle(2'b11, t_rd, t_rd, '0, 2'b00, 1'b0);
			n++;
		end
		idle_cycle();
		compare_tag("dp_avail_o", 6'd0, phys_tag_t'(dp_avail_o));
		run_cycle('0, '0, '0, '0, 2'b01, 1'b0);
		idle_cycle();
		compare_tag("dp_avail_o", 6'd1, phys_tag_t'(dp_avail_o));
		report_test("5 free list empty");

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, u_dut.u_sva.sva_errors);
		if (errors == 0 && u_dut.u_sva.sva_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: all.f
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/spec_map.sv
hdl/arch_map.sv
hdl/restore_counter.sv
hdl/recovery_fsm.sv
hdl/rename_top.sv
sim/rename_sva.sv
sim/rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the rename stage testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rename_tb -f all.f -o rename_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/rename_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
